// File: logic/bch_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// bch syndrome package
// GF(2^4) field constants, register map
// and elaboration-time field math
//~~~~~~~~~~~~~~~~~~~~
package bch_pkg;

	localparam int M = 4;                 // field degree
	localparam int N = (1 << M) - 1;      // code length, 15
	localparam int T = 2;                 // correctable errors -> syndromes 1, 3
	localparam logic [M:0] PRIM_POLY = 5'b10011; // x^4 + x + 1

	// apb register offsets
	localparam logic [7:0] ADDR_FIRST = 8'h00; // first chunk, restarts division
	localparam logic [7:0] ADDR_NEXT  = 8'h04; // following chunks
	localparam logic [7:0] ADDR_SYN   = 8'h08; // {flag, s3, s1}, read only

	typedef logic [M-1:0] gf_t;

	// beats needed to carry one codeword
	function automatic int chunks_per_word(input int bits);
		return (N + bits - 1) / bits;
	endfunction

	// shift and add product, reduced by the field polynomial
	function automatic gf_t gf_mult(input gf_t a, input gf_t b);
		gf_t acc;
		gf_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < M; i++) begin
			if (b[i])
				acc ^= sh;
			sh = sh[M-1] ? ((sh << 1) ^ PRIM_POLY[M-1:0]) : (sh << 1); // times alpha
		end
		return acc;
	endfunction

	// alpha^e, exponent taken mod N
	function automatic gf_t gf_pow(input int e);
		int k;
		gf_t v;
		k = e % N;
		if (k < 0)
			k += N;
		v = gf_t'(1);
		for (int i = 0; i < k; i++)
			v = gf_mult(v, gf_t'(2)); // alpha is x
		return v;
	endfunction

	// minimal polynomial of alpha^j
	// product of (x - beta) over the conjugates beta = alpha^(j*2^k)
	function automatic logic [M:0] min_poly(input int j);
		logic [M:0][M-1:0] coef;  // coefficients are field elements until the end
		logic [M:0] res;
		gf_t root;
		gf_t first;
		logic done;
		coef = '0;
		coef[0] = gf_t'(1);
		first = gf_pow(j);
		root = first;
		done = 1'b0;
		for (int k = 0; k < M; k++) begin
			if (!done) begin
				for (int d = M; d > 0; d--)
					coef[d] = coef[d-1] ^ gf_mult(coef[d], root); // times (x + root)
				coef[0] = gf_mult(coef[0], root);
				root = gf_mult(root, root); // next conjugate
				done = (root == first);
			end
		end
		for (int d = 0; d <= M; d++)
			res[d] = |coef[d]; // lands in GF(2), only 0 or 1 remain
		return res;
	endfunction

endpackage

// File: logic/syndrome_remainder.sv
//~~~~~~~~~~~~~~~~~~~~
// syndrome remainder
// multi-bit LFSR, r(x) mod f_j(x), BITS bits per beat
// optional register stage on the input term
//~~~~~~~~~~~~~~~~~~~~
module syndrome_remainder import bch_pkg::*; #(
	parameter int SYN             = 1,
	parameter int BITS            = 5,
	parameter int PIPELINE_STAGES = 1
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            ce,        // one beat of BITS bits
	input  logic            start,     // beat opens a new word
	input  logic [BITS-1:0] data_in,   // msb is highest power
	output logic [M-1:0]    remainder
);

	localparam logic [M:0] F_POLY = min_poly(SYN);

	// x^k mod f for every power that can reach the register
	typedef logic [BITS+M-1:0][M-1:0] xmod_t;

	function automatic xmod_t xmod_table();
		xmod_t tab;
		logic [M-1:0] v;
		v = '0;
		v[0] = 1'b1;
		for (int k = 0; k < BITS + M; k++) begin
			tab[k] = v;
			v = v[M-1] ? ((v << 1) ^ F_POLY[M-1:0]) : (v << 1); // feedback taps of f
		end
		return tab;
	endfunction

	localparam xmod_t XMOD = xmod_table();

	logic [M-1:0] in_term;    // data_in mod f
	logic [M-1:0] lfsr_term;  // remainder * x^BITS mod f
	logic         upd;        // register update, ce after the stage
	logic         upd_first;
	logic [M-1:0] upd_term;
	logic [M-1:0] lfsr;

	// low bits land directly, bits at or above M fold through f
	always_comb begin
		in_term = '0;
		for (int i = 0; i < BITS; i++)
			if (data_in[i])
				in_term ^= XMOD[i];
	end

	// register bits shifted out past degree M fold back the same way
	always_comb begin
		lfsr_term = '0;
		for (int i = 0; i < M; i++)
			if (lfsr[i])
				lfsr_term ^= XMOD[i + BITS];
	end

	generate
		if (PIPELINE_STAGES > 0) begin : g_pipe
			// start and folded term travel together, one cycle
			always_ff @(posedge clk or negedge arst_n) begin
				if (!arst_n) begin
					upd       <= 1'b0;
					upd_first <= 1'b0;
					upd_term  <= '0;
				end else begin
					upd <= ce;
					if (ce) begin
						upd_first <= start;
						upd_term  <= in_term;
					end
				end
			end
		end else begin : g_direct
			assign upd       = ce;
			assign upd_first = start;
			assign upd_term  = in_term;
		end
	endgenerate

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			lfsr <= '0;
		else if (upd) begin
			if (upd_first)
				lfsr <= upd_term;               // drop old word
			else
				lfsr <= lfsr_term ^ upd_term;
		end
	end

	assign remainder = lfsr; // b_j(x), straight from the register

endmodule

// File: logic/syndrome_expand.sv
//~~~~~~~~~~~~~~~~~~~~
// syndrome expand
// evaluates b_j(x) at alpha^j, constant GF(2) matrix
//~~~~~~~~~~~~~~~~~~~~
module syndrome_expand import bch_pkg::*; #(
	parameter int SYN = 1
) (
	input  logic [M-1:0] remainder, // b_j coefficients, bit i is x^i
	output logic [M-1:0] syndrome   // S_j, standard basis
);

	typedef logic [M-1:0][M-1:0] mat_t;

	// column i holds alpha^(SYN*i)
	function automatic mat_t build_matrix();
		mat_t mat;
		gf_t col;
		gf_t step;
		step = gf_pow(SYN);
		col = gf_t'(1);
		for (int i = 0; i < M; i++) begin
			mat[i] = col;
			col = gf_mult(col, step); // next power of alpha^SYN
		end
		return mat;
	endfunction

	localparam mat_t COLS = build_matrix();

	// sum of selected columns
	always_comb begin
		syndrome = '0;
		for (int i = 0; i < M; i++)
			if (remainder[i])
				syndrome ^= COLS[i];
	end

endmodule

// File: logic/syndrome_bank.sv
//~~~~~~~~~~~~~~~~~~~~
// syndrome bank
// one divider and expander per odd syndrome,
// plus the nonzero flag
//~~~~~~~~~~~~~~~~~~~~
module syndrome_bank import bch_pkg::*; #(
	parameter int BITS            = 5,
	parameter int PIPELINE_STAGES = 1
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            chunk_valid,
	input  logic            chunk_first,
	input  logic [BITS-1:0] chunk_data,
	output logic [M-1:0]    syn1,
	output logic [M-1:0]    syn3,
	output logic            syn_nonzero
);

	logic [T-1:0][M-1:0] rem; // b_j per index
	logic [T-1:0][M-1:0] syn; // S_j per index

	generate
		for (genvar k = 0; k < T; k++) begin : g_syn
			// odd indices only, even ones follow by squaring
			syndrome_remainder #(
				.SYN             (2 * k + 1),
				.BITS            (BITS),
				.PIPELINE_STAGES (PIPELINE_STAGES)
			) u_rem (
				.clk       (clk),
				.arst_n    (arst_n),
				.ce        (chunk_valid),  // same stream to every divider
				.start     (chunk_first),
				.data_in   (chunk_data),
				.remainder (rem[k])
			);

			syndrome_expand #(
				.SYN (2 * k + 1)
			) u_exp (
				.remainder (rem[k]),
				.syndrome  (syn[k])
			);
		end
	endgenerate

	assign syn1 = syn[0];
	assign syn3 = syn[1];
	assign syn_nonzero = |syn; // any error seen

endmodule

// File: logic/syndrome_apb.sv
//~~~~~~~~~~~~~~~~~~~~
// syndrome apb slave
// chunk writes become strobes to the bank,
// syndrome reads wait for chunks in flight
//~~~~~~~~~~~~~~~~~~~~
module syndrome_apb import bch_pkg::*; #(
	parameter int BITS            = 5,
	parameter int PIPELINE_STAGES = 1
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic [7:0]      paddr,
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  logic [31:0]     pwdata,
	output logic [31:0]     prdata,
	output logic            pready,
	output logic            pslverr,
	output logic            chunk_valid,   // one cycle per accepted chunk
	output logic            chunk_first,
	output logic [BITS-1:0] chunk_data,
	input  logic [M-1:0]    syn1,
	input  logic [M-1:0]    syn3,
	input  logic            syn_nonzero
);

	// room for every chunk that can be in the divider pipe
	localparam int CNT_W = $clog2(PIPELINE_STAGES + 2) + 1;

	logic             hit_first;
	logic             hit_next;
	logic             hit_syn;
	logic             mapped;
	logic             xfer_done;  // access cycle with pready
	logic             wr_chunk;
	logic             ready_nxt;
	logic             err_nxt;
	logic             done;       // chunk has reached the lfsr
	logic [CNT_W-1:0] in_flight;
	logic [31:0]      syn_word;

	assign hit_first = (paddr == ADDR_FIRST);
	assign hit_next  = (paddr == ADDR_NEXT);
	assign hit_syn   = (paddr == ADDR_SYN);
	assign mapped    = hit_first | hit_next | hit_syn;

	assign xfer_done = psel & penable & pready;
	assign wr_chunk  = xfer_done & pwrite & (hit_first | hit_next);

	// pready is raised one cycle ahead, so writes finish on the first access cycle
	// syndrome reads hold off until nothing is in flight
	assign ready_nxt = psel & ~xfer_done & (pwrite | ~hit_syn | (in_flight == '0));
	assign err_nxt   = ready_nxt & (~mapped | (pwrite & hit_syn)); // bad addr or ro write

	assign syn_word = {{(31 - 2 * M){1'b0}}, syn_nonzero, syn3, syn1};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pready  <= 1'b0;
			pslverr <= 1'b0;
			prdata  <= '0;
		end else begin
			pready  <= ready_nxt;
			pslverr <= err_nxt;
			// sampled once the bank has settled, zero otherwise
			prdata  <= (ready_nxt & ~pwrite & hit_syn) ? syn_word : '0;
		end
	end

	// chunk strobe, cycle after the completing access
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			chunk_valid <= 1'b0;
			chunk_first <= 1'b0;
		end else begin
			chunk_valid <= wr_chunk;
			if (wr_chunk)
				chunk_first <= hit_first; // first chunk restarts the division
		end
	end

	always_ff @(posedge clk) begin
		if (wr_chunk)
			chunk_data <= pwdata[BITS-1:0];
	end

	// strobe delayed to match the divider input stage
	generate
		if (PIPELINE_STAGES == 0) begin : g_no_dly
			assign done = chunk_valid;
		end else begin : g_dly
			logic [PIPELINE_STAGES-1:0] vld_dly;

			always_ff @(posedge clk or negedge arst_n) begin
				if (!arst_n)
					vld_dly <= '0;
				else
					vld_dly <= (vld_dly << 1) | PIPELINE_STAGES'(chunk_valid);
			end

			assign done = vld_dly[PIPELINE_STAGES-1];
		end
	endgenerate

	// up on accept, down when the lfsr takes it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			in_flight <= '0;
		else
			in_flight <= in_flight + CNT_W'(wr_chunk) - CNT_W'(done);
	end

endmodule

// File: logic/bch_syndrome_top.sv
//~~~~~~~~~~~~~~~~~~~~
// bch syndrome top
// apb slave in front of the syndrome bank
//~~~~~~~~~~~~~~~~~~~~
module bch_syndrome_top import bch_pkg::*; #(
	parameter int BITS            = 5,
	parameter int PIPELINE_STAGES = 1
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	logic            chunk_valid;
	logic            chunk_first;
	logic [BITS-1:0] chunk_data;
	logic [M-1:0]    syn1;
	logic [M-1:0]    syn3;
	logic            syn_nonzero;

	syndrome_apb #(
		.BITS            (BITS),
		.PIPELINE_STAGES (PIPELINE_STAGES)  // in-flight tracking must match the bank
	) u_apb (
		.clk         (clk),
		.arst_n      (arst_n),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.chunk_valid (chunk_valid),
		.chunk_first (chunk_first),
		.chunk_data  (chunk_data),
		.syn1        (syn1),
		.syn3        (syn3),
		.syn_nonzero (syn_nonzero)
	);

	syndrome_bank #(
		.BITS            (BITS),
		.PIPELINE_STAGES (PIPELINE_STAGES)
	) u_bank (
		.clk         (clk),
		.arst_n      (arst_n),
		.chunk_valid (chunk_valid),
		.chunk_first (chunk_first),
		.chunk_data  (chunk_data),
		.syn1        (syn1),
		.syn3        (syn3),
		.syn_nonzero (syn_nonzero)
	);

endmodule

// File: testbench/tb_bch_ref.svh
//~~~~~~~~~~~~~~~~~~~~
// bch reference model and apb driver
// Horner evaluation of r(alpha^j), GF(2) products
//~~~~~~~~~~~~~~~~~~~~
`ifndef TB_BCH_REF_SVH
`define TB_BCH_REF_SVH

	localparam logic [31:0] F1 = 32'h13;  // x^4+x+1, minimal poly of alpha
	localparam logic [31:0] F3 = 32'h1f;  // x^4+x^3+x^2+x+1, alpha^3
	localparam int MSG_BITS = N - 8;      // generator has degree 8

	// times alpha, x^4 folds back to x+1
	function automatic logic [M-1:0] times_alpha(input logic [M-1:0] v);
		return {v[M-2:0], 1'b0} ^ (v[M-1] ? PRIM_POLY[M-1:0] : '0);
	endfunction

	function automatic logic [M-1:0] alpha_pow(input int e);
		logic [M-1:0] v;
		v = 1;
		for (int k = 0; k < e % N; k++)
			v = times_alpha(v);
		return v;
	endfunction

	// r(alpha^j), top coefficient first
	function automatic logic [M-1:0] horner_eval(input logic [N-1:0] r, input int j);
		logic [M-1:0] acc;
		acc = '0;
		for (int i = N - 1; i >= 0; i--) begin
			for (int k = 0; k < j; k++)
				acc = times_alpha(acc); // acc * alpha^j
			acc[0] = acc[0] ^ r[i];
		end
		return acc;
	endfunction

	// carry-less product over GF(2)
	function automatic logic [31:0] poly_mult(input logic [31:0] a, input logic [31:0] b);
		logic [31:0] acc;
		acc = '0;
		for (int i = 0; i < 16; i++)
			if (b[i])
				acc ^= a << i;
		return acc;
	endfunction

	localparam logic [31:0] GEN = poly_mult(F1, F3); // g(x) = f1 * f3

	// one apb transfer, setup then access until pready
	// entered and left 1 unit after a rising edge
	task automatic bus_transfer(input logic wr, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata,
			output logic err, output int waits);
		waits   = 0;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		while (!pready) begin // stalled access cycles
			@(posedge clk);
			#1;
			waits++;
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// codeword as CHUNKS writes, top chunk first
	task automatic send_word(input logic [N-1:0] word);
		logic [CHUNKS*BITS-1:0] padded;
		logic [31:0]            rd;
		logic                   err;
		int                     waits;
		padded = '0;
		padded[N-1:0] = word; // leading zeros pad the top chunk
		for (int c = CHUNKS - 1; c >= 0; c--) begin
			bus_transfer(1'b1, (c == CHUNKS - 1) ? ADDR_FIRST : ADDR_NEXT,
				32'(padded[c*BITS +: BITS]), rd, err, waits);
			compare_value("pslverr chunk write", 32'(err), 32'h0);
			require(waits == 0, "chunk write did not complete on its first access cycle");
		end
	endtask

`endif

// File: testbench/tb_bch_syndrome.sv
//~~~~~~~~~~~~~~~~~~~~
// bch syndrome testbench
// apb stimulus, reference checks, summary
//~~~~~~~~~~~~~~~~~~~~
module tb_bch_syndrome import bch_pkg::*; ();

	localparam int BITS      = 5;  // dut default
	localparam int CHUNKS    = chunks_per_word(BITS);
	localparam int NUM_TESTS = 7;
	localparam int MAX_WORDS = 50;
	localparam int PERIOD    = 4;
	localparam int TIMEOUT   = (NUM_TESTS * MAX_WORDS * 40 + 200) * PERIOD;

	logic        clk;
	logic        arst_n;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	integer seed = 32'h5554ea8d;
	int checks       = 0;
	int errors       = 0;
	int test_base    = 0; // errors when the current test began
	int tests_passed = 0;
	int tests_failed = 0;

	bch_syndrome_top dut (.*);

	`include "tb_bch_ref.svh"

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT);
		$display("timeout: run did not finish within %0d time units", TIMEOUT);
		$display("Verification failed");
		$finish;
	end

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got == exp)
		else begin
			$display("Mismatch at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic require(input logic cond, input string what);
		checks++;
		assert (cond)
		else begin
			$display("Error at time %0t: %s", $time, what);
			errors++;
		end
	endtask

	// read {flag, s3, s1} and compare
	task automatic read_syndromes(input logic [M-1:0] s1, input logic [M-1:0] s3,
			output int waits);
		logic [31:0] rd;
		logic        err;
		bus_transfer(1'b0, ADDR_SYN, 32'h0, rd, err, waits);
		compare_value("prdata[3:0] s1", 32'(rd[3:0]), 32'(s1));
		compare_value("prdata[7:4] s3", 32'(rd[7:4]), 32'(s3));
		compare_value("prdata[8] flag", 32'(rd[8]), 32'(|{s1, s3})); // any syndrome set
		compare_value("prdata[31:9]", 32'(rd[31:9]), 32'h0);
		compare_value("pslverr syndrome read", 32'(err), 32'h0);
	endtask

	task automatic end_test(input string name);
		if (errors == test_base) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_base);
		end
		test_base = errors;
	endtask

	initial begin
		logic [31:0]  rnd;
		logic [31:0]  prod;
		logic [N-1:0] word;
		logic [M-1:0] s1;
		logic [M-1:0] s3;
		logic [31:0]  rd;
		logic         err;
		int           waits;
		int           p1;
		int           p2;
		arst_n  = 1'b0;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;

		read_syndromes('0, '0, waits); // nothing written yet
		end_test("reset read");

		send_word('0);
		read_syndromes('0, '0, waits);
		end_test("zero word");

		for (int i = 0; i < 10; i++) begin
			rnd  = $random(seed);
			prod = poly_mult(GEN, 32'(rnd[MSG_BITS-1:0])); // multiple of g
			send_word(prod[N-1:0]);
			read_syndromes('0, '0, waits);
		end
		end_test("valid codewords");

		for (int i = 0; i < 20; i++) begin
			rnd  = $random(seed);
			prod = poly_mult(GEN, 32'(rnd[MSG_BITS-1:0]));
			p1   = int'(rnd[11:8]) % N;
			p2   = (p1 + 1 + int'(rnd[15:12]) % (N - 1)) % N; // never p1
			word = prod[N-1:0] ^ (N'(1) << p1);
			s1   = alpha_pow(p1);
			s3   = alpha_pow(3 * p1);
			if (i % 2 == 1) begin  // odd passes get a second error
				word = word ^ (N'(1) << p2);
				s1   = s1 ^ alpha_pow(p2);
				s3   = s3 ^ alpha_pow(3 * p2);
			end
			send_word(word);
			read_syndromes(s1, s3, waits);
		end
		end_test("single and double errors");

		for (int i = 0; i < MAX_WORDS; i++) begin
			rnd = $random(seed);
			// stale partial word, dropped by the next ADDR_FIRST
			if (rnd[31])
				bus_transfer(1'b1, ADDR_NEXT, 32'(rnd[20:16]), rd, err, waits);
			if (rnd[30])
				bus_transfer(1'b1, ADDR_FIRST, 32'(rnd[25:21]), rd, err, waits);
			word = rnd[N-1:0];
			send_word(word);
			read_syndromes(horner_eval(word, 1), horner_eval(word, 3), waits);
		end
		end_test("random words and restart");

		rnd  = $random(seed);
		word = rnd[N-1:0] | N'(1);
		send_word(word);
		read_syndromes(horner_eval(word, 1), horner_eval(word, 3), waits); // right behind last chunk
		require(waits > 0, "syndrome read did not wait for chunks in flight");
		end_test("read back-pressure");

		bus_transfer(1'b0, 8'h10, 32'h0, rd, err, waits);
		compare_value("pslverr unmapped read", 32'(err), 32'h1);
		bus_transfer(1'b1, 8'h0c, 32'h1f, rd, err, waits);
		compare_value("pslverr unmapped write", 32'(err), 32'h1);
		bus_transfer(1'b1, ADDR_SYN, 32'h1ff, rd, err, waits);
		compare_value("pslverr syndrome write", 32'(err), 32'h1);
		read_syndromes(horner_eval(word, 1), horner_eval(word, 3), waits); // unchanged
		end_test("error responses");

		$display("tests passed %0d, failed %0d, checks %0d, errors %0d",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+testbench
logic/bch_pkg.sv
logic/syndrome_remainder.sv
logic/syndrome_expand.sv
logic/syndrome_bank.sv
logic/syndrome_apb.sv
logic/bch_syndrome_top.sv
testbench/tb_bch_syndrome.sv

// File: Makefile
# Verilator flow for the BCH syndrome block

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_bch_syndrome
RTL_TOP   ?= bch_syndrome_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) testbench/tb_bch_ref.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
